/* dual_pol_spectrometer.f */
+incdir+hdl
hdl/spec_sample_pkg.sv
hdl/spec_bus_pkg.sv
hdl/complex_power.sv
hdl/vector_accumulator.sv
hdl/spectrometer_lane.sv
hdl/spectrum_store.sv
hdl/dual_pol_spectrometer.sv
tb/dual_pol_spectrometer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f dual_pol_spectrometer.f \
    --top-module dual_pol_spectrometer_tb -o sim_dual_pol \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_dual_pol > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb/dual_pol_spectrometer_tb.sv */
`include "spec_config.svh"

module dual_pol_spectrometer_tb;

    localparam int VL = `SPEC_VECTOR_LEN;
    localparam int NUM_ROWS = 4;

    // acc_len, random samples, idle gaps, aborted partial frame first
    typedef struct packed {
        logic [7:0] acc_len;
        logic       random_mode;
        logic       gap;
        logic       abort;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'd1, 1'b0, 1'b0, 1'b0},
        '{8'd3, 1'b1, 1'b0, 1'b0},
        '{8'd2, 1'b1, 1'b1, 1'b0},
        '{8'd2, 1'b1, 1'b0, 1'b1}
    };

    logic                      clk;
    logic                      cnt_rst;
    spec_sample_pkg::lane_in_t data_in;
    spec_bus_pkg::wb_req_t     wb_req;
    spec_bus_pkg::wb_rsp_t     wb_rsp;
    logic                      spec_ready;
    integer                    seed;
    int                        cycles = 0;
    int                        cycle_limit = 0;
    int                        ready_cycles = 0;
    int                        expected [VL];

    dual_pol_spectrometer dut (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .data_in    (data_in),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .spec_ready (spec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // counts every cycle with spec_ready high
    always @(negedge clk) begin
        if (spec_ready === 1'b1) ready_cycles = ready_cycles + 1;
    end

    function automatic int power_of(spec_sample_pkg::cplx_t s);
        int re;
        int im;
        re = $signed(s.re);
        im = $signed(s.im);
        return re * re + im * im;
    endfunction

    // fixed pattern where bin 0 hits -128 in both lanes
    function automatic spec_sample_pkg::cplx_t fixed_sample(int bin, int frame, bit pol_b);
        spec_sample_pkg::cplx_t s;
        if (!pol_b) begin
            s.re = `SPEC_DIN_WIDTH'(bin * 37 - 128 + frame * 5);
            s.im = `SPEC_DIN_WIDTH'(bin * 11 + frame);
        end else begin
            s.re = `SPEC_DIN_WIDTH'(127 - bin * 19);
            s.im = `SPEC_DIN_WIDTH'(bin * 3 + frame - 128);
        end
        return s;
    endfunction

    task automatic check_value(input string what, input int idx, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s %0d got 0x%08h, expected 0x%08h",
                     $time, what, idx, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // one classic cycle held until ack
    task automatic bus_cycle(input logic we, input int adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(negedge clk);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = `SPEC_WB_ADR_WIDTH'(adr);
        wb_req.dat_w = wdata;
        do @(negedge clk); while (wb_rsp.ack !== 1'b1);
        rdata  = wb_rsp.dat_r;
        wb_req = '0;
    endtask

    task automatic send_beat(input logic sync, input spec_sample_pkg::cplx_t a,
                             input spec_sample_pkg::cplx_t b);
        @(negedge clk);
        data_in.valid = 1'b1;
        data_in.sync  = sync;
        data_in.a     = a;
        data_in.b     = b;
    endtask

    task automatic run_row(input row_t row, input int idx);
        spec_sample_pkg::cplx_t a;
        spec_sample_pkg::cplx_t b;
        logic [31:0]            r;
        for (int i = 0; i < VL; i++) expected[i] = 0;
        bus_cycle(1'b1, spec_bus_pkg::ADR_ACC_LEN, 32'(row.acc_len), r);
        bus_cycle(1'b0, spec_bus_pkg::ADR_ACC_LEN, '0, r);
        check_value("acc_len of row", idx, r, 32'(row.acc_len));
        // junk that the next sync must throw away
        if (row.abort) begin
            for (int k = 0; k < 3; k++) begin
                {a, b} = 32'($random(seed));
                send_beat(k == 0, a, b);
            end
        end
        for (int f = 0; f < row.acc_len; f++) begin
            for (int bin = 0; bin < VL; bin++) begin
                if (row.random_mode) begin
                    {a, b} = 32'($random(seed));
                end else begin
                    a = fixed_sample(bin, f, 1'b0);
                    b = fixed_sample(bin, f, 1'b1);
                end
                expected[bin] += power_of(a) + power_of(b);
                send_beat(f == 0 && bin == 0, a, b);
                if (row.gap && !(f == row.acc_len - 1 && bin == VL - 1)) begin
                    @(negedge clk);
                    data_in = '0;
                end
            end
        end
        // spec_ready is one cycle wide and comes 5 cycles after the last beat
        for (int k = 1; k <= 6; k++) begin
            @(negedge clk);
            data_in = '0;
            check_value("spec_ready at cycle", k, 32'(spec_ready), 32'(k == 5));
        end
        for (int bin = 0; bin < VL; bin++) begin
            bus_cycle(1'b0, bin, '0, r);
            check_value("bin", bin, r, 32'(expected[bin]));
        end
        check_value("spec_ready cycles after row", idx, 32'(ready_cycles), 32'(idx + 1));
    endtask

    initial begin
        logic [31:0] r;
        seed = 32'h8c8f6e1c;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += int'(ROWS[i].acc_len) * VL * 2 + 100;
        end
        cnt_rst = 1'b1;
        data_in = '0;
        wb_req  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        cnt_rst = 1'b0;
        bus_cycle(1'b0, spec_bus_pkg::ADR_ACC_LEN, '0, r);
        check_value("acc_len after reset", 0, r, 32'(`SPEC_ACC_LEN_DEFAULT));
        check_value("spec_ready cycles after reset", 0, 32'(ready_cycles), 32'd0);
        for (int i = 0; i < NUM_ROWS; i++) run_row(ROWS[i], i);
        // zero frames is stored as one
        bus_cycle(1'b1, spec_bus_pkg::ADR_ACC_LEN, 32'd0, r);
        bus_cycle(1'b0, spec_bus_pkg::ADR_ACC_LEN, '0, r);
        check_value("acc_len after zero write", 0, r, 32'd1);
        // unmapped space acks and reads zero
        bus_cycle(1'b1, VL + 4, 32'hdeadbeef, r);
        bus_cycle(1'b0, spec_bus_pkg::ADR_ACC_LEN, '0, r);
        check_value("acc_len after unmapped write", 0, r, 32'd1);
        for (int adr = VL + 1; adr < (1 << `SPEC_WB_ADR_WIDTH); adr++) begin
            bus_cycle(1'b0, adr, '0, r);
            check_value("unmapped address", adr, r, 32'd0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* hdl/dual_pol_spectrometer.sv */
`include "spec_config.svh"

module dual_pol_spectrometer (
    input  logic                        clk,
    input  logic                        cnt_rst,
    input  spec_sample_pkg::lane_in_t   data_in,
    input  spec_bus_pkg::wb_req_t       wb_req,
    output spec_bus_pkg::wb_rsp_t       wb_rsp,
    output logic                        spec_ready
);

    spec_sample_pkg::bin_word_t           acc_a;
    spec_sample_pkg::bin_word_t           acc_b;
    logic [`SPEC_ACC_LEN_WIDTH-1:0]       acc_len;

    // polarization a
    spectrometer_lane lane_a (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .din       (data_in.a),
        .din_valid (data_in.valid),
        .sync      (data_in.sync),
        .acc_len   (acc_len),
        .dout      (acc_a)
    );

    // polarization b
    spectrometer_lane lane_b (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .din       (data_in.b),
        .din_valid (data_in.valid),
        .sync      (data_in.sync),
        .acc_len   (acc_len),
        .dout      (acc_b)
    );

    spectrum_store u_store (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .acc_a      (acc_a),
        .acc_b      (acc_b),
        .acc_len    (acc_len),
        .spec_ready (spec_ready),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

endmodule

/* hdl/spectrum_store.sv */
`include "spec_config.svh"

module spectrum_store (
    input  logic                            clk,
    input  logic                            cnt_rst,
    input  spec_sample_pkg::bin_word_t      acc_a,
    input  spec_sample_pkg::bin_word_t      acc_b,
    output logic [`SPEC_ACC_LEN_WIDTH-1:0]  acc_len,
    output logic                            spec_ready,
    input  spec_bus_pkg::wb_req_t           wb_req,
    output spec_bus_pkg::wb_rsp_t           wb_rsp
);

    localparam int VL = `SPEC_VECTOR_LEN;
    localparam int BW = `SPEC_BIN_WIDTH;
    localparam int AW = `SPEC_ACC_WIDTH;
    localparam int LW = `SPEC_ACC_LEN_WIDTH;

    // registered write into the total RAM
    typedef struct packed {
        logic          en;
        logic          last;
        logic [BW-1:0] bin;
        logic [AW-1:0] sum;
    } wr_t;

    logic [AW-1:0] ram [VL];
    wr_t           wr;
    logic          req;
    logic          take;
    logic          held;
    logic          ack_q;
    logic [31:0]   rd_data;
    logic [31:0]   dat_r_q;

    // both lanes run in lockstep, so lane a gives the tags
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            wr.en      <= 1'b0;
            wr.last    <= 1'b0;
            spec_ready <= 1'b0;
        end else begin
            wr.en      <= acc_a.valid && acc_a.final_frame;
            wr.last    <= acc_a.valid && acc_a.last;
            wr.bin     <= acc_a.bin;
            wr.sum     <= acc_a.value + acc_b.value;
            spec_ready <= wr.en && wr.last;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            ram[wr.bin] <= wr.sum;
        end
    end

    // wishbone classic with one ack per strobe
    assign req  = wb_req.cyc && wb_req.stb;
    assign take = req && !held && !ack_q;

    always_comb begin
        if (wb_req.adr < `SPEC_WB_ADR_WIDTH'(VL)) begin
            rd_data = 32'(ram[wb_req.adr[BW-1:0]]);
        end else if (wb_req.adr == spec_bus_pkg::ADR_ACC_LEN) begin
            rd_data = 32'(acc_len);
        end else begin
            rd_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            ack_q   <= 1'b0;
            held    <= 1'b0;
            acc_len <= LW'(`SPEC_ACC_LEN_DEFAULT);
        end else begin
            ack_q <= take;
            // stays set until the master drops stb
            held  <= req && (held || ack_q);
            if (take && wb_req.we && wb_req.adr == spec_bus_pkg::ADR_ACC_LEN) begin
                // a zero length becomes one frame
                acc_len <= (wb_req.dat_w[LW-1:0] == '0) ? LW'(1) : wb_req.dat_w[LW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    a_lanes_aligned: assert property (
        @(posedge clk) disable iff (cnt_rst)
        (acc_a.valid == acc_b.valid) &&
        (!acc_a.valid || (acc_a.bin == acc_b.bin && acc_a.last == acc_b.last &&
                          acc_a.final_frame == acc_b.final_frame))
    ) else $error("spectrum_store: lanes out of step");

    // a strobe held past its ack gets no second ack
    a_ack_once_per_strobe: assert property (
        @(posedge clk) disable iff (cnt_rst)
        $past(wb_rsp.ack) && $past(req) && req |=> !wb_rsp.ack
    ) else $error("spectrum_store: second ack for one strobe");

endmodule

/* hdl/spectrometer_lane.sv */
`include "spec_config.svh"

module spectrometer_lane (
    input  logic                            clk,
    input  logic                            cnt_rst,
    input  spec_sample_pkg::cplx_t          din,
    input  logic                            din_valid,
    input  logic                            sync,
    input  logic [`SPEC_ACC_LEN_WIDTH-1:0]  acc_len,
    output spec_sample_pkg::bin_word_t      dout
);

    localparam int BW = `SPEC_BIN_WIDTH;
    localparam int FW = `SPEC_ACC_LEN_WIDTH;

    // bin position of a beat carried alongside the power pipeline
    typedef struct packed {
        logic [BW-1:0] bin;
        logic          first_frame;
        logic          last_frame;
    } tag_t;

    logic [BW-1:0]              bin_cnt;
    logic [FW-1:0]              frame_cnt;
    logic                       armed;
    logic                       beat;
    logic [BW-1:0]              cur_bin;
    logic [FW-1:0]              cur_frame;
    tag_t                       cur_tag;
    tag_t                       tag_d [2];
    logic [`SPEC_POWER_WIDTH-1:0] power;
    logic                       power_valid;

    // sync restarts at bin 0 frame 0 even mid-stream
    assign cur_bin   = sync ? '0 : bin_cnt;
    assign cur_frame = sync ? '0 : frame_cnt;
    // nothing counts until the first sync
    assign beat      = din_valid && (sync || armed);

    assign cur_tag.bin         = cur_bin;
    assign cur_tag.first_frame = (cur_frame == '0);
    assign cur_tag.last_frame  = (cur_frame == acc_len - FW'(1));

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            armed     <= 1'b0;
            bin_cnt   <= '0;
            frame_cnt <= '0;
        end else if (beat) begin
            armed <= 1'b1;
            if (cur_bin == BW'(`SPEC_VECTOR_LEN - 1)) begin
                bin_cnt   <= '0;
                // wrap after acc_len frames without a sync
                frame_cnt <= cur_tag.last_frame ? '0 : cur_frame + FW'(1);
            end else begin
                bin_cnt   <= cur_bin + BW'(1);
                frame_cnt <= cur_frame;
            end
        end
    end

    // two cycles to match complex_power
    always_ff @(posedge clk) begin
        tag_d[0] <= cur_tag;
        tag_d[1] <= tag_d[0];
    end

    complex_power u_power (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .din        (din),
        .din_valid  (beat),
        .dout       (power),
        .dout_valid (power_valid)
    );

    vector_accumulator u_acc (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .din         (power),
        .din_valid   (power_valid),
        .bin         (tag_d[1].bin),
        .first_frame (tag_d[1].first_frame),
        .last_frame  (tag_d[1].last_frame),
        .dout        (dout)
    );

    a_frame_in_range: assert property (
        @(posedge clk) disable iff (cnt_rst)
        armed |-> frame_cnt < acc_len
    ) else $error("spectrometer_lane: frame count reached acc_len");

endmodule

/* hdl/vector_accumulator.sv */
`include "spec_config.svh"

module vector_accumulator (
    input  logic                          clk,
    input  logic                          cnt_rst,
    input  logic [`SPEC_POWER_WIDTH-1:0]  din,
    input  logic                          din_valid,
    input  logic [`SPEC_BIN_WIDTH-1:0]    bin,
    input  logic                          first_frame,
    input  logic                          last_frame,
    output spec_sample_pkg::bin_word_t    dout
);

    localparam int VL = `SPEC_VECTOR_LEN;
    localparam int AW = `SPEC_ACC_WIDTH;

    // one running sum per bin
    logic [AW-1:0] mem [VL];
    logic [AW-1:0] sum;
    logic          top_bin;

    // first frame drops whatever an earlier accumulation left behind
    always_comb begin
        if (first_frame) begin
            sum = AW'(din);
        end else begin
            sum = mem[bin] + AW'(din);
        end
    end

    assign top_bin = (bin == `SPEC_BIN_WIDTH'(VL - 1));

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem[bin] <= sum;
        end
    end

    // running sum goes out in every frame
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            dout.valid <= 1'b0;
        end else begin
            dout.valid <= din_valid;
            if (din_valid) begin
                dout.last        <= last_frame && top_bin;
                dout.final_frame <= last_frame;
                dout.bin         <= bin;
                dout.value       <= sum;
            end
        end
    end

    // back to back beats must walk through the bins
    a_bin_advances: assert property (
        @(posedge clk) disable iff (cnt_rst)
        din_valid && $past(din_valid) |-> bin != $past(bin)
    ) else $error("vector_accumulator: same bin on consecutive beats");

endmodule

/* hdl/complex_power.sv */
`include "spec_config.svh"

module complex_power (
    input  logic                          clk,
    input  logic                          cnt_rst,
    input  spec_sample_pkg::cplx_t        din,
    input  logic                          din_valid,
    output logic [`SPEC_POWER_WIDTH-1:0]  dout,
    output logic                          dout_valid
);

    logic signed [`SPEC_POWER_WIDTH-1:0] re_prod;
    logic signed [`SPEC_POWER_WIDTH-1:0] im_prod;
    logic [`SPEC_POWER_WIDTH-1:0]        re_sq;
    logic [`SPEC_POWER_WIDTH-1:0]        im_sq;
    logic [1:0]                          valid_sr;

    // products are sign extended to full width before multiplying
    assign re_prod = din.re * din.re;
    assign im_prod = din.im * din.im;

    // stage 1 squares, stage 2 sum
    always_ff @(posedge clk) begin
        re_sq <= re_prod;
        im_sq <= im_prod;
        dout  <= re_sq + im_sq;
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            valid_sr <= 2'b00;
        end else begin
            valid_sr <= {valid_sr[0], din_valid};
        end
    end

    assign dout_valid = valid_sr[1];

endmodule

/* hdl/spec_bus_pkg.sv */
`include "spec_config.svh"

package spec_bus_pkg;

    // master to slave
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`SPEC_WB_ADR_WIDTH-1:0] adr;
        logic [31:0]                  dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // bins sit at 0 .. VECTOR_LEN-1 with the register right above them
    localparam logic [`SPEC_WB_ADR_WIDTH-1:0] ADR_ACC_LEN = `SPEC_WB_ADR_WIDTH'(`SPEC_VECTOR_LEN);

endpackage

/* hdl/spec_sample_pkg.sv */
`include "spec_config.svh"

package spec_sample_pkg;

    // one complex FFT output sample
    typedef struct packed {
        logic signed [`SPEC_DIN_WIDTH-1:0] re;
        logic signed [`SPEC_DIN_WIDTH-1:0] im;
    } cplx_t;

    // both polarizations share valid and sync
    typedef struct packed {
        logic  valid;
        logic  sync;
        cplx_t a;
        cplx_t b;
    } lane_in_t;

    // last marks the top bin of the final frame only
    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic                       final_frame;
        logic [`SPEC_BIN_WIDTH-1:0] bin;
        logic [`SPEC_ACC_WIDTH-1:0] value;
    } bin_word_t;

endpackage

/* hdl/spec_config.svh */
`ifndef SPEC_CONFIG_SVH
`define SPEC_CONFIG_SVH

// signed width of re and im
`define SPEC_DIN_WIDTH 8

// bins per frame (at least 4)
`define SPEC_VECTOR_LEN 8
`define SPEC_BIN_WIDTH 3

// re^2 + im^2 peaks at 32768 and still fits
`define SPEC_POWER_WIDTH (2 * `SPEC_DIN_WIDTH)

// running sums and the total spectrum
`define SPEC_ACC_WIDTH 32

// wishbone word address
`define SPEC_WB_ADR_WIDTH 4

// frames per accumulation
`define SPEC_ACC_LEN_WIDTH 8
`define SPEC_ACC_LEN_DEFAULT 1

`endif
